//--- design/osf_stream_pkg.sv
/*
  Beat field types and widths of the outbound stream formatter.
  Every stage imports this package for the stored beat layout.
*/
`default_nettype none

package osf_stream_pkg;

  // ########################################
  // Field widths
  // ########################################

  localparam int TDATA_W    = 64;
  localparam int TSTRB_W    = 8;
  localparam int BYTE_CNT_W = 4;

  // Stored beat is {tlast, tstrb, tdata}.
  localparam int BEAT_W = TDATA_W + TSTRB_W + 1;

  // Field positions inside a stored beat.
  localparam int STRB_LSB = TDATA_W;
  localparam int LAST_POS = BEAT_W - 1;

  // ########################################
  // Types
  // ########################################

  // One beat of payload.
  typedef logic [TDATA_W-1:0] tdata_t;

  // Byte-valid mask of a beat.
  typedef logic [TSTRB_W-1:0] tstrb_t;

  // Valid bytes in a beat, 0 to 8.
  typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

  // Beat as held in the FIFOs.
  typedef logic [BEAT_W-1:0] beat_t;

endpackage

`default_nettype wire

//--- design/osf_ctl_pkg.sv
/*
  Control definitions of the stream formatter: FIFO depth defaults
  and the encoding of the frame merge state.
*/
`default_nettype none

package osf_ctl_pkg;

  // Default FIFO depths, power of two and 4 or more.
  localparam int IB_DEPTH_DEF = 16;
  localparam int OB_DEPTH_DEF = 16;

  // Source selected by the frame merge.
  typedef enum logic {
    MERGE_PDT  = 1'b0,
    MERGE_DATA = 1'b1
  } merge_state_t;

endpackage

`default_nettype wire

//--- design/osf_beat_fifo.sv
/*
  Synchronous FIFO of stream beats. Full gates the writer, empty and
  rdata show the head, rd pops it on the clock edge.
*/
`timescale 1ns/100ps
`default_nettype none

module osf_beat_fifo
  import osf_stream_pkg::*, osf_ctl_pkg::*;
#(
  parameter int DEPTH = IB_DEPTH_DEF
)
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr,
  input  beat_t wdata,
  input  logic  rd,
  output logic  full,
  output logic  empty,
  output beat_t rdata
);

  localparam int AW = $clog2(DEPTH);

  beat_t      mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        push;
  logic        pop;

  assign push = wr && !full;
  assign pop  = rd && !empty;

  // ########################################
  // Pointers
  // ########################################

  // Extra top bit tells a full buffer from an empty one.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // ########################################
  // Storage
  // ########################################

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr[AW-1:0]] <= wdata;
    end
  end

  // Head is read straight from the array.
  assign rdata = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

//--- design/osf_frame_merge.sv
/*
  Frame merge stage. Moves one whole pdt frame and then one whole data
  frame into the outbound FIFO, one beat per cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module osf_frame_merge
  import osf_stream_pkg::*, osf_ctl_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pdt_empty,
  input  logic  data_empty,
  input  beat_t pdt_rdata,
  input  beat_t data_rdata,
  input  logic  ob_full,
  output logic  pdt_rd,
  output logic  data_rd,
  output logic  ob_wr,
  output beat_t ob_wdata
);

  merge_state_t state;
  logic         src_empty;
  beat_t        src_beat;
  logic         move;

  // Selected source head.
  always_comb
  begin
    if (state == MERGE_PDT)
    begin
      src_empty = pdt_empty;
      src_beat  = pdt_rdata;
    end
    else
    begin
      src_empty = data_empty;
      src_beat  = data_rdata;
    end
  end

  assign move     = !src_empty && !ob_full;
  assign pdt_rd   = move && (state == MERGE_PDT);
  assign data_rd  = move && (state == MERGE_DATA);
  assign ob_wr    = move;
  assign ob_wdata = src_beat;

  // Swap sources only after a last beat, so frames never interleave.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= MERGE_PDT;
    end
    else if (move && src_beat[LAST_POS])
    begin
      state <= (state == MERGE_PDT) ? MERGE_DATA : MERGE_PDT;
    end
  end

endmodule

`default_nettype wire

//--- design/osf_ob_master.sv
/*
  Outbound master. Registers the FIFO head onto the ob port under
  valid/ready and emits byte and frame statistics strobes.
*/
`timescale 1ns/100ps
`default_nettype none

module osf_ob_master
  import osf_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      fifo_empty,
  input  beat_t     fifo_rdata,
  input  logic      halt,
  input  logic      force_bp,
  input  logic      ob_ready,
  output logic      fifo_rd,
  output logic      ob_valid,
  output tdata_t    ob_tdata,
  output tstrb_t    ob_tstrb,
  output logic      ob_tlast,
  output logic      byte_cnt_stb,
  output byte_cnt_t byte_cnt_amt,
  output logic      frame_cnt_stb
);

  logic accept;

  assign accept = ob_valid && ob_ready;

  // Fetch when the register frees up this cycle and nothing holds us off.
  assign fifo_rd = (!ob_valid || ob_ready) && !fifo_empty && !halt && !force_bp;

  // ########################################
  // Output register
  // ########################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ob_valid <= 1'b0;
    end
    else if (fifo_rd)
    begin
      ob_valid <= 1'b1;
    end
    else if (ob_ready)
    begin
      ob_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fifo_rd)
    begin
      ob_tdata <= fifo_rdata[TDATA_W-1:0];
      ob_tstrb <= fifo_rdata[STRB_LSB +: TSTRB_W];
      ob_tlast <= fifo_rdata[LAST_POS];
    end
  end

  // ########################################
  // Statistics
  // ########################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      byte_cnt_stb  <= 1'b0;
      byte_cnt_amt  <= '0;
      frame_cnt_stb <= 1'b0;
    end
    else
    begin
      byte_cnt_stb  <= accept;
      frame_cnt_stb <= accept && ob_tlast;
      if (accept)
      begin
        byte_cnt_amt <= byte_cnt_t'($countones(ob_tstrb));
      end
    end
  end

endmodule

`default_nettype wire

//--- design/osf_core.sv
/*
  Outbound stream formatter top level. Buffers the pdt and data streams,
  merges them frame by frame and drives the ob port.
*/
`timescale 1ns/100ps
`default_nettype none

module osf_core
  import osf_stream_pkg::*, osf_ctl_pkg::*;
#(
  parameter int IB_DEPTH = IB_DEPTH_DEF,
  parameter int OB_DEPTH = OB_DEPTH_DEF
)
(
  input  logic      clk,
  input  logic      rst_n,
  // pdt stream
  input  logic      pdt_valid,
  output logic      pdt_ready,
  input  tdata_t    pdt_tdata,
  input  tstrb_t    pdt_tstrb,
  input  logic      pdt_tlast,
  // data stream
  input  logic      data_valid,
  output logic      data_ready,
  input  tdata_t    data_tdata,
  input  tstrb_t    data_tstrb,
  input  logic      data_tlast,
  // Outbound port and hold-off levels.
  output logic      ob_valid,
  input  logic      ob_ready,
  output tdata_t    ob_tdata,
  output tstrb_t    ob_tstrb,
  output logic      ob_tlast,
  input  logic      halt,
  input  logic      force_bp,
  // Statistics.
  output logic      byte_cnt_stb,
  output byte_cnt_t byte_cnt_amt,
  output logic      frame_cnt_stb
);

  logic  pdt_full, pdt_empty, pdt_rd;
  logic  data_full, data_empty, data_rd;
  logic  ob_fifo_full, ob_fifo_empty, ob_fifo_wr, ob_fifo_rd;
  beat_t pdt_rdata, data_rdata, ob_fifo_wdata, ob_fifo_rdata;

  // ########################################
  // Inbound FIFOs
  // ########################################

  assign pdt_ready  = !pdt_full;
  assign data_ready = !data_full;

  osf_beat_fifo #(.DEPTH(IB_DEPTH)) u_pdt_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (pdt_valid && pdt_ready),
    .wdata ({pdt_tlast, pdt_tstrb, pdt_tdata}),
    .rd    (pdt_rd),
    .full  (pdt_full),
    .empty (pdt_empty),
    .rdata (pdt_rdata)
  );

  osf_beat_fifo #(.DEPTH(IB_DEPTH)) u_data_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (data_valid && data_ready),
    .wdata ({data_tlast, data_tstrb, data_tdata}),
    .rd    (data_rd),
    .full  (data_full),
    .empty (data_empty),
    .rdata (data_rdata)
  );

  // ########################################
  // Merge and outbound
  // ########################################

  osf_frame_merge u_frame_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .pdt_empty  (pdt_empty),
    .data_empty (data_empty),
    .pdt_rdata  (pdt_rdata),
    .data_rdata (data_rdata),
    .ob_full    (ob_fifo_full),
    .pdt_rd     (pdt_rd),
    .data_rd    (data_rd),
    .ob_wr      (ob_fifo_wr),
    .ob_wdata   (ob_fifo_wdata)
  );

  osf_beat_fifo #(.DEPTH(OB_DEPTH)) u_ob_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (ob_fifo_wr),
    .wdata (ob_fifo_wdata),
    .rd    (ob_fifo_rd),
    .full  (ob_fifo_full),
    .empty (ob_fifo_empty),
    .rdata (ob_fifo_rdata)
  );

  osf_ob_master u_ob_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .fifo_empty    (ob_fifo_empty),
    .fifo_rdata    (ob_fifo_rdata),
    .halt          (halt),
    .force_bp      (force_bp),
    .ob_ready      (ob_ready),
    .fifo_rd       (ob_fifo_rd),
    .ob_valid      (ob_valid),
    .ob_tdata      (ob_tdata),
    .ob_tstrb      (ob_tstrb),
    .ob_tlast      (ob_tlast),
    .byte_cnt_stb  (byte_cnt_stb),
    .byte_cnt_amt  (byte_cnt_amt),
    .frame_cnt_stb (frame_cnt_stb)
  );

endmodule

`default_nettype wire

//--- testbench/osf_core_asserts.sv
/*
  Protocol assertions on the ob port, bound into the core.
*/
`timescale 1ns/100ps
`default_nettype none

module osf_core_asserts
  import osf_stream_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  input logic   ob_valid,
  input logic   ob_ready,
  input tdata_t ob_tdata
);

  // A presented beat stays until it is taken.
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ob_valid && !ob_ready |=> ob_valid)
    else $error("ob_valid dropped before ob_ready");

  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ob_valid && !ob_ready |=> $stable(ob_tdata))
    else $error("ob_tdata changed while the beat was stalled");

  // Reset clears the output register.
  a_reset_low: assert property (@(posedge clk) !rst_n |-> !ob_valid)
    else $error("ob_valid high during reset");

endmodule

bind osf_core osf_core_asserts u_ob_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .ob_valid (ob_valid),
  .ob_ready (ob_ready),
  .ob_tdata (ob_tdata)
);

`default_nettype wire

//--- testbench/osf_core_tb.sv
/*
  Testbench of the stream formatter. Random pdt and data frames go in,
  and the ob port and statistics strobes are checked against a reference.
*/
`timescale 1ns/100ps
`default_nettype none

module osf_core_tb
  import osf_stream_pkg::*;
();

  localparam int NUM_FRAMES = 40;

  logic      clk = 1'b0;
  logic      rst_n = 1'b0;
  logic      pdt_valid = 1'b0;
  tdata_t    pdt_tdata = '0;
  tstrb_t    pdt_tstrb = '0;
  logic      pdt_tlast = 1'b0;
  logic      pdt_ready;
  logic      data_valid = 1'b0;
  tdata_t    data_tdata = '0;
  tstrb_t    data_tstrb = '0;
  logic      data_tlast = 1'b0;
  logic      data_ready;
  logic      ob_ready = 1'b0;
  logic      halt = 1'b0;
  logic      force_bp = 1'b0;
  logic      ob_valid;
  tdata_t    ob_tdata;
  tstrb_t    ob_tstrb;
  logic      ob_tlast;
  logic      byte_cnt_stb;
  byte_cnt_t byte_cnt_amt;
  logic      frame_cnt_stb;

  logic [31:0] rng = 32'h6fa6_7b4f;
  beat_t       pdt_q[$];
  beat_t       data_q[$];
  beat_t       exp_q[$];
  int          exp_amt_q[$];
  int          exp_bytes = 0;
  int          exp_frames = 0;
  int          pdt_idx = 0;
  int          data_idx = 0;
  int          pdt_gap = 0;
  int          data_gap = 0;
  int          ob_idx = 0;
  int          amt_idx = 0;
  int          byte_total = 0;
  int          frame_total = 0;
  int          hold_left = 1;
  int          cycle_cnt = 0;
  int          limit = 1000000;
  logic        saw_ib_stall = 1'b0;
  logic        running = 1'b0;

  osf_core UUT (.*);

  always #20 clk = ~clk;

  // ########################################
  // Random numbers and reference model
  // ########################################

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic beat_t make_beat(input logic last);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] s;
    hi = next_rand();
    lo = next_rand();
    s  = next_rand();
    return {last, s[7:0], hi, lo};
  endfunction

  // Frames of 1 to 6 beats with last on the final beat.
  task automatic gen_frames();
    int len;
    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      len = 1 + int'(next_rand() % 6);
      for (int i = 0; i < len; i++)
        pdt_q.push_back(make_beat(i == len - 1));
      len = 1 + int'(next_rand() % 6);
      for (int i = 0; i < len; i++)
        data_q.push_back(make_beat(i == len - 1));
    end
  endtask

  function automatic int count_bytes(input tstrb_t s);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++)
      if (s[i])
        n++;
    return n;
  endfunction

  function automatic void push_expected(input beat_t b);
    exp_q.push_back(b);
    exp_amt_q.push_back(count_bytes(b[71:64]));
    exp_bytes += count_bytes(b[71:64]);
    if (b[72])
      exp_frames++;
  endfunction

  // Outbound order is pdt frame n, then data frame n, beats unchanged.
  function automatic void build_expected();
    int   pi;
    int   di;
    logic last;
    pi = 0;
    di = 0;
    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      last = 1'b0;
      while (!last)
      begin
        push_expected(pdt_q[pi]);
        last = pdt_q[pi][72];
        pi++;
      end
      last = 1'b0;
      while (!last)
      begin
        push_expected(data_q[di]);
        last = data_q[di][72];
        di++;
      end
    end
  endfunction

  // ########################################
  // Checks
  // ########################################

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] act,
                             input logic [63:0] exp);
    if (act !== exp)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Judges the beat that the coming rising edge accepts.
  // Under a hold only the beat already in the output register may go.
  task automatic check_outbound();
    beat_t e;
    if (!halt && !force_bp)
      hold_left = 1;
    else if (!ob_valid)
      hold_left = 0;
    if (ob_valid && ob_ready)
    begin
      if (ob_idx >= exp_q.size())
      begin
        $display("Outbound beat %0d arrived beyond the expected %0d", ob_idx, exp_q.size());
        abort_run();
      end
      else
      begin
        e = exp_q[ob_idx];
        check_value("ob_tdata", ob_tdata, e[63:0]);
        check_value("ob_tstrb", 64'(ob_tstrb), 64'(e[71:64]));
        check_value("ob_tlast", 64'(ob_tlast), 64'(e[72]));
        ob_idx++;
        if (halt || force_bp)
        begin
          if (hold_left == 0)
          begin
            $display("A beat not presented before halt or force_bp was accepted");
            abort_run();
          end
          else
            hold_left = 0;
        end
      end
    end
  endtask

  task automatic check_stats();
    if (byte_cnt_stb)
    begin
      if (amt_idx >= exp_amt_q.size())
      begin
        $display("A byte count strobe came beyond the expected %0d", exp_amt_q.size());
        abort_run();
      end
      else
      begin
        check_value("byte_cnt_amt", 64'(byte_cnt_amt), 64'(exp_amt_q[amt_idx]));
        check_value("frame_cnt_stb", 64'(frame_cnt_stb), 64'(exp_q[amt_idx][72]));
        byte_total += int'(byte_cnt_amt);
        amt_idx++;
      end
    end
    else
      check_value("frame_cnt_stb", 64'(frame_cnt_stb), 64'(0));
    if (frame_cnt_stb)
      frame_total++;
  endtask

  // ########################################
  // Stimulus
  // ########################################

  // Hold-off windows repeat every 400 cycles.
  task automatic drive_streams();
    int phase;
    phase = cycle_cnt % 400;
    if (pdt_valid)
    begin
      pdt_valid = 1'b0;
      pdt_idx++;
    end
    if (pdt_gap != 0)
      pdt_gap--;
    else if (pdt_idx < pdt_q.size() && pdt_ready)
    begin
      {pdt_tlast, pdt_tstrb, pdt_tdata} = pdt_q[pdt_idx];
      pdt_valid = 1'b1;
      pdt_gap = int'(next_rand() % 3);
    end
    if (data_valid)
    begin
      data_valid = 1'b0;
      data_idx++;
    end
    if (data_gap != 0)
      data_gap--;
    else if (data_idx < data_q.size() && data_ready)
    begin
      {data_tlast, data_tstrb, data_tdata} = data_q[data_idx];
      data_valid = 1'b1;
      data_gap = int'(next_rand() % 3);
    end
    halt = (phase >= 60 && phase < 80);
    force_bp = (phase >= 260 && phase < 280);
    if (phase >= 150 && phase < 210)
      ob_ready = 1'b0;
    else
      ob_ready = (next_rand() % 4) != 0;
    if (!pdt_ready || !data_ready)
      saw_ib_stall = 1'b1;
  endtask

  always @(negedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > limit)
    begin
      $display("Timeout after %0d cycles, %0d of %0d beats received",
               limit, ob_idx, exp_q.size());
      abort_run();
    end
    else if (running)
    begin
      drive_streams();
      check_outbound();
      check_stats();
    end
  end

  initial
  begin
    gen_frames();
    build_expected();
    limit = exp_q.size() * 16 + 500;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_value("ob_valid", 64'(ob_valid), 64'(0));
    check_value("byte_cnt_stb", 64'(byte_cnt_stb), 64'(0));
    check_value("frame_cnt_stb", 64'(frame_cnt_stb), 64'(0));
    check_value("pdt_ready", 64'(pdt_ready), 64'(1));
    check_value("data_ready", 64'(data_ready), 64'(1));
    running <= 1'b1;
    while (ob_idx < exp_q.size() || amt_idx < exp_q.size())
      @(negedge clk);
    // A few idle cycles catch duplicated beats or strobes.
    repeat (10) @(negedge clk);
    check_value("byte_total", 64'(byte_total), 64'(exp_bytes));
    check_value("frame_total", 64'(frame_total), 64'(exp_frames));
    check_value("ib_ready_drop", 64'(saw_ib_stall), 64'(1));
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- osf_core.f
design/osf_stream_pkg.sv
design/osf_ctl_pkg.sv
design/osf_beat_fifo.sv
design/osf_frame_merge.sv
design/osf_ob_master.sv
design/osf_core.sv
testbench/osf_core_asserts.sv
testbench/osf_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status reports the result.
verilator --binary --timing --assert -f osf_core.f --top-module osf_core_tb -o osf_core_sim \
  && ./obj_dir/osf_core_sim \
  || exit 1
